// File: build.f
+incdir+verilog
verilog/sram_pkg.sv
verilog/bank_port_if.sv
verilog/bank_router.sv
verilog/sram_bank.sv
verilog/read_return_mux.sv
verilog/banked_sram_top.sv
verification/tb_banked_sram.sv

// File: Bender.yml
package:
  name: banked_sram

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sram_pkg.sv
      - verilog/bank_port_if.sv
      - verilog/bank_router.sv
      - verilog/sram_bank.sv
      - verilog/read_return_mux.sv
      - verilog/banked_sram_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_banked_sram.sv

// File: verification/tb_banked_sram.sv
/*
  self-checking testbench of the banked scratchpad, seeded random stimulus.
  reference model tracks written bytes, bytes never written are not compared.
  read latency follows SRAM_OUT_REGS.
*/
`timescale 1ns/1ps
`include "sram_config.svh"

module tb_banked_sram;
  import sram_pkg::*;

  // cycles from read strobe to visible data
  localparam int Lat         = (`SRAM_OUT_REGS != 0) ? 2 : 1;
  localparam int DrainCycles = 2;
  localparam int ResetCycles = 3;
  localparam int IdleCycles  = 4;
  localparam int FillCycles  = 2 * NumWords;
  localparam int ByteCycles  = 200;
  localparam int CollCycles  = 150;
  localparam int RandCycles  = 2000;
  // all stimulus cycles plus margin
  localparam int TimeoutCycles = ResetCycles + IdleCycles + FillCycles + ByteCycles
                               + CollCycles + RandCycles + 4 * DrainCycles + 100;

  logic                      clk_i;
  logic                      rst_ni;
  logic       [NumPorts-1:0] req_i;
  logic       [NumPorts-1:0] we_i;
  word_addr_u [NumPorts-1:0] addr_i;
  data_t      [NumPorts-1:0] wdata_i;
  be_t        [NumPorts-1:0] be_i;
  data_t      [NumPorts-1:0] rdata_o;

  integer      seed = 32'he8b2_752a;
  int unsigned cyc_count = 0;
  int          errors = 0;
  int          errors_base = 0;

  // reference memory and per byte written flags
  data_t model_mem [NumWords];
  be_t   model_wr  [NumWords];
  // expected reads in flight, stage Lat-1 completes at the next edge
  logic  pipe_v [NumPorts][2];
  data_t pipe_d [NumPorts][2];
  data_t pipe_m [NumPorts][2];
  // last completed read, rdata_o must show it until the next one
  data_t hold_d [NumPorts];
  data_t hold_m [NumPorts];

  banked_sram_top banked_sram_top_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .be_i    (be_i),
    .rdata_o (rdata_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc_count <= cyc_count + 1;
  end

  initial begin : watchdog
    wait (cyc_count >= TimeoutCycles);
    $display("run timed out after %0d cycles", cyc_count);
    $display("test failed");
    $finish;
  end

  // byte enables widened to a bit mask
  function automatic data_t byte_mask(input be_t be);
    data_t m;
    for (int j = 0; j < BeWidth; j++) begin
      m[j*8 +: 8] = {8{be[j]}};
    end
    return m;
  endfunction

  task automatic set_idle();
    req_i   = '0;
    we_i    = '0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
  endtask

  task automatic set_write(input int p, input int a, input data_t d, input be_t be);
    req_i[p]       = 1'b1;
    we_i[p]        = 1'b1;
    addr_i[p].flat = AddrWidth'(a);
    wdata_i[p]     = d;
    be_i[p]        = be;
  endtask

  task automatic set_read(input int p, input int a);
    req_i[p]       = 1'b1;
    we_i[p]        = 1'b0;
    addr_i[p].flat = AddrWidth'(a);
  endtask

  // reads take the old word, then writes land in port order
  task automatic update_model();
    data_t wm;
    int    a;
    for (int p = 0; p < NumPorts; p++) begin
      a = int'(addr_i[p].flat);
      pipe_v[p][0] = req_i[p] && !we_i[p];
      pipe_d[p][0] = model_mem[a];
      pipe_m[p][0] = byte_mask(model_wr[a]);
    end
    for (int p = 0; p < NumPorts; p++) begin
      if (req_i[p] && we_i[p]) begin
        a = int'(addr_i[p].flat);
        wm = byte_mask(be_i[p]);
        model_mem[a] = (model_mem[a] & ~wm) | (wdata_i[p] & wm);
        model_wr[a]  = model_wr[a] | be_i[p];
      end
    end
  endtask

  task automatic check_outputs();
    for (int p = 0; p < NumPorts; p++) begin
      if (pipe_v[p][Lat-1]) begin
        hold_d[p] = pipe_d[p][Lat-1];
        hold_m[p] = pipe_m[p][Lat-1];
      end
      assert ((rdata_o[p] & hold_m[p]) === (hold_d[p] & hold_m[p])) else begin
        $display("FAILED rdata_o[%0d] expected %h actual %h (mask %h, cycle %0d)",
                 p, hold_d[p] & hold_m[p], rdata_o[p], hold_m[p], cyc_count);
        errors++;
      end
      // age the in-flight reads by one edge
      if (Lat > 1) begin
        pipe_v[p][1] = pipe_v[p][0];
        pipe_d[p][1] = pipe_d[p][0];
        pipe_m[p][1] = pipe_m[p][0];
      end
    end
  endtask

  // one clock, checked 1 ns after the edge, next inputs follow at once
  task automatic tick();
    update_model();
    @(posedge clk_i);
    #1;
    check_outputs();
  endtask

  task automatic drain();
    repeat (DrainCycles) begin
      set_idle();
      tick();
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d mismatches", name, errors - errors_base);
    errors_base = errors;
  endtask

  initial begin : main
    int a;
    for (int i = 0; i < NumWords; i++) begin
      model_mem[i] = '0;
      model_wr[i]  = '0;
    end
    for (int p = 0; p < NumPorts; p++) begin
      pipe_v[p][0] = 1'b0;
      pipe_v[p][1] = 1'b0;
      hold_d[p]    = '0;
      hold_m[p]    = '1;
    end
    set_idle();
    rst_ni = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // idle after reset, outputs stay zero
    repeat (IdleCycles) tick();
    report_test("reset");

    // full words through alternating ports, then every word from both ports
    for (int i = 0; i < NumWords; i++) begin
      set_idle();
      set_write(i % NumPorts, i, data_t'($random(seed)), '1);
      tick();
    end
    for (int i = 0; i < NumWords; i++) begin
      set_idle();
      set_read(0, i);
      set_read(1, NumWords - 1 - i);
      tick();
    end
    drain();
    report_test("fill and read back");

    // partial write on port 0, read back on port 1
    for (int i = 0; i < ByteCycles / 2; i++) begin
      a = {$random(seed)} % NumWords;
      set_idle();
      set_write(0, a, data_t'($random(seed)), be_t'($random(seed)));
      tick();
      set_idle();
      set_read(1, a);
      tick();
    end
    drain();
    report_test("byte enables");

    // double write, then read against a write, then read the result
    for (int i = 0; i < CollCycles / 3; i++) begin
      a = {$random(seed)} % NumWords;
      set_idle();
      set_write(0, a, data_t'($random(seed)), be_t'($random(seed)));
      set_write(1, a, data_t'($random(seed)), be_t'($random(seed)));
      tick();
      set_idle();
      set_read(0, a);
      set_write(1, a, data_t'($random(seed)), '1);
      tick();
      set_idle();
      set_read(1, a);
      tick();
    end
    drain();
    report_test("collisions");

    // mixed traffic, a narrow window now and then to force collisions
    for (int i = 0; i < RandCycles; i++) begin
      set_idle();
      for (int p = 0; p < NumPorts; p++) begin
        a = {$random(seed)} % NumWords;
        if (({$random(seed)} % 4) == 0) begin
          a = a % 8;
        end
        case ({$random(seed)} % 3)
          0: set_read(p, a);
          1: set_write(p, a, data_t'($random(seed)), be_t'($random(seed)));
          default: ;
        endcase
      end
      tick();
    end
    drain();
    report_test("random traffic");

    $display("all tests done, %0d mismatches in %0d cycles", errors, cyc_count);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: verilog/banked_sram_top.sv
/*
  two port scratchpad, words interleaved over the banks by the low address bits.
  requests are single cycle strobes, no handshake and no back-pressure.
  read latency is 1 cycle, 2 with SRAM_OUT_REGS set. rdata_o holds between reads.
*/
`timescale 1ns/1ps
`include "sram_config.svh"

module banked_sram_top (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // one strobe per port, we_i selects write over read
  input  logic                 [sram_pkg::NumPorts-1:0] req_i,
  input  logic                 [sram_pkg::NumPorts-1:0] we_i,
  // flat word address, bank in the low bits
  input  sram_pkg::word_addr_u [sram_pkg::NumPorts-1:0] addr_i,
  input  sram_pkg::data_t      [sram_pkg::NumPorts-1:0] wdata_i,
  input  sram_pkg::be_t        [sram_pkg::NumPorts-1:0] be_i,
  // data of the last read on each port
  output sram_pkg::data_t      [sram_pkg::NumPorts-1:0] rdata_o
);
  import sram_pkg::*;

  // banks and read return must agree on the latency
  localparam bit OutRegs = (`SRAM_OUT_REGS != 0);

  // one request/response bundle per bank
  bank_port_if bank_if [NumBanks] ();

  // address decode and strobe steering
  bank_router bank_router_i (
    .req_i   (req_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .be_i    (be_i),
    .bank_o  (bank_if)
  );

  // bank array
  // each bank stores every NumBanks-th word of the address space
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    sram_bank #(
      .OutRegs (OutRegs)
    ) sram_bank_i (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .port_i (bank_if[b])
    );
  end

  // per port return of the last read bank's data
  // sees the raw port strobes, so it tracks reads to any bank
  read_return_mux #(
    .OutRegs (OutRegs)
  ) read_return_mux_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .bank_i  (bank_if),
    .rdata_o (rdata_o)
  );

endmodule

// File: verilog/read_return_mux.sv
/*
  picks, per port, the read data of the bank that port read last.
  bank index is delayed to match the bank read latency, adds no cycle.
  output holds between reads because every bank keeps its read register.
*/
`timescale 1ns/1ps

module read_return_mux #(
  // must match the banks, selects the index delay
  parameter bit OutRegs = 1'b0
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                 [sram_pkg::NumPorts-1:0] req_i,
  input  logic                 [sram_pkg::NumPorts-1:0] we_i,
  input  sram_pkg::word_addr_u [sram_pkg::NumPorts-1:0] addr_i,
  bank_port_if.drain                                    bank_i [sram_pkg::NumBanks],
  output sram_pkg::data_t      [sram_pkg::NumPorts-1:0] rdata_o
);
  import sram_pkg::*;

  // flattened view of all banks' read data
  data_t     [NumBanks-1:0][NumPorts-1:0] bank_rdata;
  // bank index of the last read, aligned with the first read stage
  bank_sel_t [NumPorts-1:0]               sel_q;
  // index aligned with the data actually presented by the banks
  bank_sel_t [NumPorts-1:0]               sel_qq;

  for (genvar b = 0; b < NumBanks; b++) begin : gen_collect
    assign bank_rdata[b] = bank_i[b].rdata;
  end

  // capture the bank on each read strobe, keep it otherwise
  // reset to bank 0, whose read registers are zero as well
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_sel
    if (!rst_ni) begin
      sel_q <= '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        if (req_i[p] && !we_i[p]) begin
          sel_q[p] <= addr_i[p].br.bank;
        end
      end
    end
  end

  if (OutRegs) begin : gen_sel_delay
    // second stage mirrors the bank output register
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_sel_delay
      if (!rst_ni) begin
        sel_qq <= '0;
      end else begin
        sel_qq <= sel_q;
      end
    end
  end else begin : gen_no_sel_delay
    assign sel_qq = sel_q;
  end

  always_comb begin : p_select
    for (int p = 0; p < NumPorts; p++) begin
      rdata_o[p] = bank_rdata[sel_qq[p]][p];
    end
  end

endmodule

// File: verilog/sram_bank.sv
/*
  dual ported bank with byte enabled writes and a registered read.
  same word written by both ports: higher port number wins per byte.
  read and write to one word in a cycle returns the old word.
  array contents are undefined until written.
*/
`timescale 1ns/1ps

module sram_bank #(
  // second read register, read latency 2 instead of 1
  parameter bit OutRegs = 1'b0
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  bank_port_if.bank   port_i
);
  import sram_pkg::*;

  // storage, one row per entry
  data_t                mem_q [BankWords];
  // first read stage per port
  data_t [NumPorts-1:0] rdata_q;
  // value presented to the read return side
  data_t [NumPorts-1:0] rdata_qq;

  // write path
  // ports are visited in order, the last nonblocking update wins,
  // so port 1 overrides port 0 on the bytes both enable
  always_ff @(posedge clk_i) begin : p_write
    for (int p = 0; p < NumPorts; p++) begin
      if (port_i.req[p] && port_i.we[p]) begin
        for (int j = 0; j < BeWidth; j++) begin
          if (port_i.be[p][j]) begin
            mem_q[port_i.row[p]][j*8 +: 8] <= port_i.wdata[p][j*8 +: 8];
          end
        end
      end
    end
  end

  // read path
  // samples the array before this edge's writes land, giving old data
  // register holds its value on writes and idle cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_read
    if (!rst_ni) begin
      rdata_q <= '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        if (port_i.req[p] && !port_i.we[p]) begin
          rdata_q[p] <= mem_q[port_i.row[p]];
        end
      end
    end
  end

  if (OutRegs) begin : gen_out_reg
    // free running second stage, follows the first one a cycle later
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_out
      if (!rst_ni) begin
        rdata_qq <= '0;
      end else begin
        rdata_qq <= rdata_q;
      end
    end
  end else begin : gen_no_out_reg
    // latency 1, first stage goes straight out
    assign rdata_qq = rdata_q;
  end

  assign port_i.rdata = rdata_qq;

endmodule

// File: verilog/bank_router.sv
/*
  purely combinational steering of both ports onto the bank array.
  no arbitration: every bank has a port per request port, so nothing stalls.
*/
`timescale 1ns/1ps

module bank_router (
  input  logic                 [sram_pkg::NumPorts-1:0] req_i,
  input  logic                 [sram_pkg::NumPorts-1:0] we_i,
  input  sram_pkg::word_addr_u [sram_pkg::NumPorts-1:0] addr_i,
  input  sram_pkg::data_t      [sram_pkg::NumPorts-1:0] wdata_i,
  input  sram_pkg::be_t        [sram_pkg::NumPorts-1:0] be_i,
  bank_port_if.router                                   bank_o [sram_pkg::NumBanks]
);
  import sram_pkg::*;

  // per bank strobe vector, one bit per port
  logic [NumBanks-1:0][NumPorts-1:0] req_bank;
  // row part of each port's address
  row_t [NumPorts-1:0]               row;

  // decode the bank index out of the low address bits
  always_comb begin : p_decode
    req_bank = '0;
    for (int p = 0; p < NumPorts; p++) begin
      if (req_i[p]) begin
        req_bank[addr_i[p].br.bank][p] = 1'b1;
      end
    end
  end

  always_comb begin : p_row
    for (int p = 0; p < NumPorts; p++) begin
      row[p] = addr_i[p].br.row;
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    // only the addressed bank sees a strobe
    assign bank_o[b].req   = req_bank[b];
    // remaining fields are broadcast, they are ignored without a strobe
    assign bank_o[b].we    = we_i;
    assign bank_o[b].row   = row;
    assign bank_o[b].wdata = wdata_i;
    assign bank_o[b].be    = be_i;
  end

endmodule

// File: verilog/bank_port_if.sv
/*
  one instance per bank, holds the request fields of every port and the
  bank's read data per port. fields are packed per port, index = port number.
*/
`timescale 1ns/1ps

interface bank_port_if;
  import sram_pkg::*;

  // strobe, only raised for the addressed bank
  logic  [NumPorts-1:0] req;
  // write when set, read otherwise
  logic  [NumPorts-1:0] we;
  // row inside the bank
  row_t  [NumPorts-1:0] row;
  data_t [NumPorts-1:0] wdata;
  // byte enables, bit j covers byte j
  be_t   [NumPorts-1:0] be;
  // registered read data, holds until the next read on that port
  data_t [NumPorts-1:0] rdata;

  // router drives the request side
  modport router (
    output req, we, row, wdata, be
  );

  // bank consumes requests and returns read data
  modport bank (
    input  req, we, row, wdata, be,
    output rdata
  );

  // read return side only looks at the data
  modport drain (
    input rdata
  );

endinterface

// File: verilog/sram_pkg.sv
/*
  shared types of the banked scratchpad, widths derived from the config macros.
  the word address is bank in the low bits and row in the high bits.
*/
`include "sram_config.svh"

package sram_pkg;

  // derived sizes
  localparam int unsigned DataWidth    = `SRAM_DATA_WIDTH;
  localparam int unsigned BeWidth      = DataWidth / 8;
  localparam int unsigned NumWords     = `SRAM_NUM_WORDS;
  localparam int unsigned NumBanks     = `SRAM_NUM_BANKS;
  localparam int unsigned NumPorts     = `SRAM_NUM_PORTS;
  localparam int unsigned BankWords    = NumWords / NumBanks;
  localparam int unsigned AddrWidth    = $clog2(NumWords);
  localparam int unsigned BankSelWidth = $clog2(NumBanks);
  localparam int unsigned RowWidth     = AddrWidth - BankSelWidth;

  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [BeWidth-1:0]      be_t;
  typedef logic [RowWidth-1:0]     row_t;
  typedef logic [BankSelWidth-1:0] bank_sel_t;

  // row on top, bank index in the low bits
  typedef struct packed {
    row_t      row;
    bank_sel_t bank;
  } bank_row_t;

  // same word seen as a flat word address or as bank and row
  typedef union packed {
    logic [AddrWidth-1:0] flat;
    bank_row_t            br;
  } word_addr_u;

endpackage

// File: verilog/sram_config.svh
/*
  build-time configuration of the banked scratchpad.
  SRAM_NUM_WORDS and SRAM_NUM_BANKS must be powers of two.
  SRAM_DATA_WIDTH must be a multiple of 8.
*/
`ifndef SRAM_CONFIG_SVH
`define SRAM_CONFIG_SVH

// width of one data word in bits
`define SRAM_DATA_WIDTH 32

// total words over all banks
`define SRAM_NUM_WORDS 256

// interleave factor, low address bits pick the bank
`define SRAM_NUM_BANKS 4

// independent request ports, each bank has one physical port per request port
`define SRAM_NUM_PORTS 2

// 1 adds a second read register, read latency becomes 2
`define SRAM_OUT_REGS 0

`endif
